//--- hw/decode_pkg.sv
`default_nettype none

package decode_pkg;

  localparam int reg_sel_width = 4;
  localparam int seg_sel_width = 2;

  typedef logic [reg_sel_width-1:0] reg_sel_t;
  typedef logic [seg_sel_width-1:0] seg_sel_t;

  // word registers in x86 encoding order
  localparam reg_sel_t reg_ax = 4'd0;
  localparam reg_sel_t reg_bx = 4'd3;
  localparam reg_sel_t reg_bp = 4'd5;
  localparam reg_sel_t reg_si = 4'd6;
  localparam reg_sel_t reg_di = 4'd7;
  // extensions above the word registers
  localparam reg_sel_t reg_tmp = 4'hc;
  localparam reg_sel_t reg_none = 4'hf;

  localparam seg_sel_t seg_ss = 2'd2;
  localparam seg_sel_t seg_ds = 2'd3;

  typedef enum logic [3:0] {
    rt_alu_rm, rt_alu_imm, rt_mov_rm, rt_mov_imm, rt_push, rt_pop, rt_incdec,
    rt_jmp_short, rt_call_near, rt_muldiv, rt_reserved, rt_trap, rt_div_exc,
    rt_ext_int, rt_ext_int_rep
  } routine_e;

  localparam int routine_count = int'(rt_ext_int_rep) + 1;

  typedef enum logic [2:0] {
    entry_opcode, entry_trap, entry_div, entry_ext, entry_ext_rep
  } entry_sel_e;

  typedef struct packed {
    routine_e routine;
    logic     need_modrm;
    logic     need_off;
    logic     need_imm;
    logic     off_size;
    logic     imm_size;
    reg_sel_t src;
    reg_sel_t dst;
    reg_sel_t base;
    reg_sel_t index;
    seg_sel_t seg;
    logic [2:0] alu_f;
  } decode_info_t;

  typedef struct packed {
    logic intr;
    logic nmir;
    logic tfl;
    logic ifl;
  } event_req_t;

  // divide step sits right after the operand fetch step of rt_muldiv
  localparam int div_step_offset = 1;

  // number of micro steps per routine
  function automatic int routine_length(routine_e r);
    case (r)
      rt_alu_rm:      return 4;
      rt_alu_imm:     return 3;
      rt_mov_rm:      return 3;
      rt_mov_imm:     return 2;
      rt_push:        return 3;
      rt_pop:         return 3;
      rt_incdec:      return 2;
      rt_jmp_short:   return 2;
      rt_call_near:   return 4;
      rt_muldiv:      return 5;
      rt_trap:        return 6;
      rt_div_exc:     return 6;
      rt_ext_int:     return 7;
      rt_ext_int_rep: return 8;
      default:        return 1;
    endcase
  endfunction

  // routines packed back to back from address 0
  function automatic int routine_start(routine_e r);
    int addr = 0;
    for (int i = 0; i < routine_count; i++)
    begin
      if (i < int'(r))
        addr += routine_length(routine_e'(i));
    end
    return addr;
  endfunction

  localparam int micro_table_size = routine_start(rt_ext_int_rep)
                                  + routine_length(rt_ext_int_rep);

endpackage

`default_nettype wire

//--- hw/opcode_lookup.sv
`timescale 1ns/1ps
`default_nettype none

module opcode_lookup
  import decode_pkg::*;
(
  input  logic [7:0]   opcode,
  input  logic [7:0]   modrm,
  input  logic         rep,
  input  logic [2:0]   sop_l,
  output decode_info_t info
);

  logic [1:0] md;
  logic [2:0] rm;
  reg_sel_t   reg_f;
  reg_sel_t   rm_f;
  logic       bp_based;
  seg_sel_t   seg_dflt;

  assign md = modrm[7:6];
  assign rm = modrm[2:0];
  assign reg_f = {1'b0, modrm[5:3]};
  assign rm_f = {1'b0, modrm[2:0]};

  // bp addressing, except mod 00 rm 110 which is a direct offset
  assign bp_based = (rm == 3'd2) || (rm == 3'd3) || (rm == 3'd6 && md != 2'b00);

  // valid override wins over the default segment
  assign seg_dflt = sop_l[2] ? sop_l[1:0] : seg_ds;

  always_comb
  begin
    info = '0;
    info.routine = rt_reserved;
    info.src = reg_none;
    info.dst = reg_none;
    info.base = reg_none;
    info.index = reg_none;
    info.seg = seg_dflt;
    info.alu_f = opcode[7] ? modrm[5:3] : opcode[5:3];

    casez (opcode)
      // alu r/m forms and mov 88..8b, d bit picks direction
      8'b00???0??, 8'b100010??:
      begin
        info.routine = opcode[7] ? rt_mov_rm : rt_alu_rm;
        info.need_modrm = 1'b1;
        info.src = opcode[1] ? rm_f : reg_f;
        info.dst = opcode[1] ? reg_f : rm_f;
      end
      // alu acc, imm
      8'b00???10?:
      begin
        info.routine = rt_alu_imm;
        info.need_imm = 1'b1;
        info.imm_size = opcode[0];
        info.dst = reg_ax;
      end
      // group 80..83, only 81 carries a word immediate
      8'b100000??:
      begin
        info.routine = rt_alu_imm;
        info.need_modrm = 1'b1;
        info.need_imm = 1'b1;
        info.imm_size = (opcode[1:0] == 2'b01);
        info.dst = rm_f;
      end
      8'b1011????:
      begin
        info.routine = rt_mov_imm;
        info.need_imm = 1'b1;
        info.imm_size = opcode[3];
        info.dst = {1'b0, opcode[2:0]};
      end
      8'b1100011?:
      begin
        info.routine = rt_mov_imm;
        info.need_modrm = 1'b1;
        info.need_imm = 1'b1;
        info.imm_size = opcode[0];
        info.dst = rm_f;
      end
      8'b01010???:
      begin
        info.routine = rt_push;
        info.src = {1'b0, opcode[2:0]};
        info.seg = seg_ss;
      end
      8'b01011???:
      begin
        info.routine = rt_pop;
        info.dst = {1'b0, opcode[2:0]};
        info.seg = seg_ss;
      end
      8'b0100????:
      begin
        info.routine = rt_incdec;
        info.dst = {1'b0, opcode[2:0]};
      end
      8'heb:
      begin
        info.routine = rt_jmp_short;
        info.need_imm = 1'b1;
      end
      8'he8:
      begin
        info.routine = rt_call_near;
        info.need_imm = 1'b1;
        info.imm_size = 1'b1;
        info.seg = seg_ss;
      end
      8'b1111011?:
      begin
        info.routine = rt_muldiv;
        info.need_modrm = 1'b1;
        info.src = rm_f;
        // 8086 quirk, rep before imul/idiv negates the result via tmp
        info.dst = (rep && modrm[3]) ? reg_tmp : reg_ax;
      end
      default:
      begin
        info.routine = rt_reserved;
      end
    endcase

    // memory operand addressing from modrm
    if (info.need_modrm)
    begin
      info.seg = sop_l[2] ? sop_l[1:0] : (bp_based ? seg_ss : seg_ds);
      case (rm)
        3'd0: {info.base, info.index} = {reg_bx, reg_si};
        3'd1: {info.base, info.index} = {reg_bx, reg_di};
        3'd2: {info.base, info.index} = {reg_bp, reg_si};
        3'd3: {info.base, info.index} = {reg_bp, reg_di};
        3'd4: {info.base, info.index} = {reg_none, reg_si};
        3'd5: {info.base, info.index} = {reg_none, reg_di};
        3'd6: {info.base, info.index} = {(md == 2'b00) ? reg_none : reg_bp, reg_none};
        default: {info.base, info.index} = {reg_bx, reg_none};
      endcase
      // disp16 for direct, disp8 for mod 01, disp16 for mod 10
      info.need_off = (md == 2'b01) || (md == 2'b10) || (md == 2'b00 && rm == 3'd6);
      info.off_size = (md != 2'b01);
    end
  end

endmodule

`default_nettype wire

//--- hw/micro_flags.sv
`timescale 1ns/1ps
`default_nettype none

module micro_flags
  import decode_pkg::*;
#(
  parameter int micro_addr_width = 8
)
(
  input  logic [micro_addr_width-1:0] addr,
  output logic                        end_seq,
  output logic                        div_step
);

  int addr_i;

  assign addr_i = int'(addr);

  // end flag at the last address of every routine
  always_comb
  begin
    // past the table, stop so a stray address cannot run on
    end_seq = (addr_i >= micro_table_size);
    for (int i = 0; i < routine_count; i++)
    begin
      if (addr_i == routine_start(routine_e'(i)) + routine_length(routine_e'(i)) - 1)
        end_seq = 1'b1;
    end
  end

  // single divide step inside rt_muldiv
  assign div_step = (addr_i == routine_start(rt_muldiv) + div_step_offset);

endmodule

`default_nettype wire

//--- hw/event_control.sv
`timescale 1ns/1ps
`default_nettype none

module event_control
  import decode_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       exec_st,
  input  logic       block,
  input  logic       end_seq,
  input  logic       div_exc,
  input  logic       wr_ss,
  input  logic       rep,
  input  event_req_t events,
  output entry_sel_e entry_sel,
  output logic       tflm,
  output logic       iflm,
  output logic       iflss,
  output logic       ext_int,
  output logic       inta,
  output logic       nmia
);

  logic tfl_q;
  logic ifl_q;
  logic ss_ok_q;
  logic trap_q;
  logic div_q;
  logic ext_d1;
  logic ext_d2;
  logic boundary;
  logic take_ext;
  logic take_trap;

  // flags only count once copied during fetch
  assign tflm = events.tfl & tfl_q;
  assign iflm = events.ifl & ifl_q;

  // shadow applies in the very cycle ss is written
  assign iflss = ~wr_ss & ss_ok_q;

  assign boundary = exec_st & end_seq & ~block;
  assign take_ext = boundary & iflss & (events.nmir | (events.intr & iflm));
  assign take_trap = boundary & iflss & tflm & ~trap_q;

  always_ff @(posedge clk or negedge rst)
  begin
    if (!rst)
    begin
      tfl_q <= 1'b0;
      ifl_q <= 1'b0;
      ss_ok_q <= 1'b0;
    end
    else if (!block)
    begin
      if (!exec_st)
      begin
        tfl_q <= events.tfl;
        ifl_q <= events.ifl;
        ss_ok_q <= 1'b1;
      end
      else if (wr_ss)
        ss_ok_q <= 1'b0;
    end
  end

  // each latch runs until the end of its service routine
  always_ff @(posedge clk or negedge rst)
  begin
    if (!rst)
    begin
      trap_q <= 1'b0;
      div_q <= 1'b0;
      ext_int <= 1'b0;
    end
    else if (!block)
    begin
      trap_q <= take_trap | (trap_q & ~end_seq);
      div_q <= div_exc | (div_q & ~end_seq);
      ext_int <= take_ext | (ext_int & ~end_seq);
    end
  end

  // ack pipeline ignores block
  always_ff @(posedge clk or negedge rst)
  begin
    if (!rst)
    begin
      ext_d1 <= 1'b0;
      ext_d2 <= 1'b0;
      inta <= 1'b0;
      nmia <= 1'b0;
    end
    else
    begin
      ext_d1 <= ext_int;
      ext_d2 <= ext_d1;
      // rise seen one stage late, so the ack lands two edges in
      inta <= ext_d1 & ~ext_d2 & ~events.nmir;
      nmia <= ext_d1 & ~ext_d2 & events.nmir;
    end
  end

  // trap first, then divide, then external
  always_comb
  begin
    if (trap_q)
      entry_sel = entry_trap;
    else if (div_q)
      entry_sel = entry_div;
    else if (ext_int)
      entry_sel = rep ? entry_ext_rep : entry_ext;
    else
      entry_sel = entry_opcode;
  end

  // one ack of one kind, two edges after the external latch rises, then quiet
  ack_timing_a: assert property (@(posedge clk) disable iff (!rst)
    $rose(ext_int) |=> ##1 ((inta ^ nmia) ##1 !(inta || nmia)));
  // ack only while the service routine still holds the latch
  ack_in_service_a: assert property (@(posedge clk) disable iff (!rst)
    (inta || nmia) |-> ext_int);

endmodule

`default_nettype wire

//--- hw/micro_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module micro_sequencer
  import decode_pkg::*;
#(
  parameter int micro_addr_width = 8,
  parameter int div_cycles = 18
)
(
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        exec_st,
  input  logic                        block,
  input  logic                        end_seq,
  input  logic                        div_step,
  input  routine_e                    routine,
  input  entry_sel_e                  entry_sel,
  output logic [micro_addr_width-1:0] seq_addr
);

  localparam int hold_width = $clog2(div_cycles + 2);
  localparam logic [hold_width-1:0] hold_total = hold_width'(div_cycles + 1);

  routine_e                    sel_rt;
  logic [micro_addr_width-1:0] base_addr;
  logic [micro_addr_width-1:0] step;
  logic [hold_width-1:0]       div_cnt;
  logic [hold_width-1:0]       hold_left;

  // service routine replaces the opcode routine
  always_comb
  begin
    case (entry_sel)
      entry_trap:    sel_rt = rt_trap;
      entry_div:     sel_rt = rt_div_exc;
      entry_ext:     sel_rt = rt_ext_int;
      entry_ext_rep: sel_rt = rt_ext_int_rep;
      default:       sel_rt = routine;
    endcase
  end

  assign base_addr = micro_addr_width'(routine_start(sel_rt));
  assign seq_addr = base_addr + step;

  // edges still to wait at the divide step
  assign hold_left = (exec_st && div_step) ? (hold_total - div_cnt) : '0;

  always_ff @(posedge clk or negedge rst)
  begin
    if (!rst)
    begin
      step <= '0;
      div_cnt <= '0;
    end
    else if (!block)
    begin
      if (!exec_st || end_seq)
        step <= '0;
      else if (hold_left == '0)
        step <= step + 1'b1;
      // count up while holding, clear once the step moves on
      div_cnt <= (hold_left != '0) ? div_cnt + 1'b1 : '0;
    end
  end

  step_range_a: assert property (@(posedge clk) disable iff (!rst)
    exec_st |-> (int'(step) < routine_length(sel_rt)));

endmodule

`default_nettype wire

//--- hw/decode_unit.sv
`timescale 1ns/1ps
`default_nettype none

module decode_unit
  import decode_pkg::*;
#(
  parameter int micro_addr_width = 8,
  parameter int div_cycles = 18
)
(
  input  logic                        clk,
  input  logic                        rst,
  input  logic [7:0]                  opcode,
  input  logic [7:0]                  modrm,
  input  logic                        rep,
  input  logic [2:0]                  sop_l,
  input  logic                        exec_st,
  input  logic                        block,
  input  logic                        div_exc,
  input  logic                        wr_ss,
  input  event_req_t                  events,
  output decode_info_t                info,
  output logic [micro_addr_width-1:0] seq_addr,
  output logic                        end_seq,
  output logic                        tflm,
  output logic                        iflm,
  output logic                        iflss,
  output logic                        inta,
  output logic                        nmia,
  output logic                        ext_int
);

  entry_sel_e entry_sel;
  logic       div_step;

  opcode_lookup lookup_i (
    .opcode (opcode),
    .modrm  (modrm),
    .rep    (rep),
    .sop_l  (sop_l),
    .info   (info)
  );

  event_control events_i (
    .clk       (clk),
    .rst       (rst),
    .exec_st   (exec_st),
    .block     (block),
    .end_seq   (end_seq),
    .div_exc   (div_exc),
    .wr_ss     (wr_ss),
    .rep       (rep),
    .events    (events),
    .entry_sel (entry_sel),
    .tflm      (tflm),
    .iflm      (iflm),
    .iflss     (iflss),
    .ext_int   (ext_int),
    .inta      (inta),
    .nmia      (nmia)
  );

  micro_sequencer #(
    .micro_addr_width (micro_addr_width),
    .div_cycles       (div_cycles)
  ) seq_i (
    .clk       (clk),
    .rst       (rst),
    .exec_st   (exec_st),
    .block     (block),
    .end_seq   (end_seq),
    .div_step  (div_step),
    .routine   (info.routine),
    .entry_sel (entry_sel),
    .seq_addr  (seq_addr)
  );

  micro_flags #(
    .micro_addr_width (micro_addr_width)
  ) flags_i (
    .addr     (seq_addr),
    .end_seq  (end_seq),
    .div_step (div_step)
  );

endmodule

`default_nettype wire

//--- test/decode_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module decode_unit_tb
  import decode_pkg::*;
();

  localparam int micro_addr_width = 8;
  localparam int div_cycles = 18;

  typedef struct packed {
    logic [7:0] opcode;
    logic       rep;
    logic [2:0] sop_l;
    event_req_t ev;
    logic       dexc;
    logic       ssw;
    logic       stall;
    logic [1:0] acks;
  } row_t;

  logic                        clk;
  logic                        rst;
  logic [7:0]                  opcode;
  logic [7:0]                  modrm;
  logic                        rep;
  logic [2:0]                  sop_l;
  logic                        exec_st;
  logic                        block;
  logic                        div_exc;
  logic                        wr_ss;
  event_req_t                  events;
  decode_info_t                info;
  logic [micro_addr_width-1:0] seq_addr;
  logic                        end_seq;
  logic                        tflm;
  logic                        iflm;
  logic                        iflss;
  logic                        inta;
  logic                        nmia;
  logic                        ext_int;

  row_t        rows[$];
  logic        rows_ready;
  logic [31:0] lfsr;

  // reference model state, updated once per edge
  int   m_step;
  int   m_hold;
  int   ack_wait;
  logic m_trap;
  logic m_div;
  logic m_ext;
  logic m_tfl;
  logic m_ifl;
  logic m_ss_ok;
  logic m_inta;
  logic m_nmia;
  logic row_done;
  logic ack_seen;
  logic blk_seen;
  logic [1:0] acks_seen;

  decode_unit #(
    .micro_addr_width (micro_addr_width),
    .div_cycles       (div_cycles)
  ) dut_i (
    .clk      (clk),
    .rst      (rst),
    .opcode   (opcode),
    .modrm    (modrm),
    .rep      (rep),
    .sop_l    (sop_l),
    .exec_st  (exec_st),
    .block    (block),
    .div_exc  (div_exc),
    .wr_ss    (wr_ss),
    .events   (events),
    .info     (info),
    .seq_addr (seq_addr),
    .end_seq  (end_seq),
    .tflm     (tflm),
    .iflm     (iflm),
    .iflss    (iflss),
    .inta     (inta),
    .nmia     (nmia),
    .ext_int  (ext_int)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // galois lfsr, one step per bit taken
  function automatic logic [7:0] random_bits(int n);
    logic [7:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v = {v[6:0], lfsr[0]};
      lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
    end
    return v;
  endfunction

  // stall about one cycle in four
  function automatic logic stall_bit(logic enable);
    return enable && (random_bits(2) == 8'd3);
  endfunction

  // x86 decode rules for the covered opcode subset
  function automatic decode_info_t expect_info(logic [7:0] op, logic [7:0] mr, logic rp,
                                               logic [2:0] so);
    decode_info_t e;
    reg_sel_t     r_reg;
    reg_sel_t     r_rm;
    logic [1:0]   mode;
    logic [2:0]   rm;
    r_reg = reg_sel_t'(mr[5:3]);
    r_rm = reg_sel_t'(mr[2:0]);
    mode = mr[7:6];
    rm = mr[2:0];
    e = '0;
    e.routine = rt_reserved;
    e.src = reg_none;
    e.dst = reg_none;
    e.base = reg_none;
    e.index = reg_none;
    e.seg = so[2] ? so[1:0] : seg_ds;
    e.alu_f = op[7] ? mr[5:3] : op[5:3];
    if ((op[7:6] == 2'b00 && !op[2]) || op[7:2] == 6'b100010)
    begin
      // d bit swaps reg and r/m
      e.routine = op[7] ? rt_mov_rm : rt_alu_rm;
      e.need_modrm = 1'b1;
      e.src = op[1] ? r_rm : r_reg;
      e.dst = op[1] ? r_reg : r_rm;
    end
    else if (op[7:6] == 2'b00 && op[2:1] == 2'b10)
    begin
      e.routine = rt_alu_imm;
      e.need_imm = 1'b1;
      e.imm_size = op[0];
      e.dst = reg_ax;
    end
    else if (op[7:2] == 6'b100000)
    begin
      // only 81 has a word immediate
      e.routine = rt_alu_imm;
      e.need_modrm = 1'b1;
      e.need_imm = 1'b1;
      e.imm_size = (op == 8'h81);
      e.dst = r_rm;
    end
    else if (op[7:4] == 4'hb || op[7:1] == 7'b1100011)
    begin
      e.routine = rt_mov_imm;
      e.need_modrm = op[6];
      e.need_imm = 1'b1;
      e.imm_size = op[6] ? op[0] : op[3];
      e.dst = op[6] ? r_rm : reg_sel_t'(op[2:0]);
    end
    else if (op[7:4] == 4'h5)
    begin
      e.routine = op[3] ? rt_pop : rt_push;
      e.src = op[3] ? reg_none : reg_sel_t'(op[2:0]);
      e.dst = op[3] ? reg_sel_t'(op[2:0]) : reg_none;
      e.seg = seg_ss;
    end
    else if (op[7:4] == 4'h4)
    begin
      e.routine = rt_incdec;
      e.dst = reg_sel_t'(op[2:0]);
    end
    else if (op == 8'heb || op == 8'he8)
    begin
      e.routine = op[0] ? rt_jmp_short : rt_call_near;
      e.need_imm = 1'b1;
      e.imm_size = !op[0];
      e.seg = op[0] ? e.seg : seg_ss;
    end
    else if (op[7:1] == 7'b1111011)
    begin
      e.routine = rt_muldiv;
      e.need_modrm = 1'b1;
      e.src = r_rm;
      e.dst = (rp && mr[3]) ? reg_tmp : reg_ax;
    end
    if (e.need_modrm)
    begin
      e.base = (rm == 3'd0 || rm == 3'd1 || rm == 3'd7) ? reg_bx :
               (rm == 3'd2 || rm == 3'd3 || (rm == 3'd6 && mode != 2'b00)) ? reg_bp :
               reg_none;
      e.index = (rm == 3'd0 || rm == 3'd2 || rm == 3'd4) ? reg_si :
                (rm == 3'd1 || rm == 3'd3 || rm == 3'd5) ? reg_di : reg_none;
      // bp based addressing defaults to ss
      e.seg = so[2] ? so[1:0] : (e.base == reg_bp ? seg_ss : seg_ds);
      // displacement per mod field, register form has none
      case (mode)
        2'b00:
        begin
          e.need_off = (rm == 3'd6);
          e.off_size = 1'b1;
        end
        2'b01:
        begin
          e.need_off = 1'b1;
          e.off_size = 1'b0;
        end
        2'b10:
        begin
          e.need_off = 1'b1;
          e.off_size = 1'b1;
        end
        default:
        begin
          e.need_off = 1'b0;
          e.off_size = 1'b1;
        end
      endcase
    end
    return e;
  endfunction

  task automatic check_info(decode_info_t got, decode_info_t exp);
    if (got !== exp)
    begin
      $display("** Error: info got %h expected %h (opcode %h modrm %h)",
               got, exp, opcode, modrm);
      $display("Checks failed");
      $fatal(1, "decode info mismatch");
    end
  endtask

  task automatic check_addr(string name, logic [micro_addr_width-1:0] got,
                            logic [micro_addr_width-1:0] exp);
    if (got !== exp)
    begin
      $display("** Error: %s got %h expected %h (opcode %h)", name, got, exp, opcode);
      $display("Checks failed");
      $fatal(1, "micro address mismatch");
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp)
    begin
      $display("** Error: %s got %h expected %h (opcode %h)", name, got, exp, opcode);
      $display("Checks failed");
      $fatal(1, "flag mismatch");
    end
  endtask

  // pair is {inta, nmia}
  task automatic check_pulse(string name, logic [1:0] got, logic [1:0] exp);
    if (got !== exp)
    begin
      $display("** Error: %s got %h expected %h (opcode %h)", name, got, exp, opcode);
      $display("Checks failed");
      $fatal(1, "acknowledge mismatch");
    end
  endtask

  // next cycle is the last step of the opcode routine
  function automatic logic at_opcode_end();
    decode_info_t e;
    e = expect_info(opcode, modrm, rep, sop_l);
    return !m_trap && !m_div && !m_ext && (m_step == routine_length(e.routine) - 1);
  endfunction

  // check at negedge, then advance the model past the coming edge
  task automatic run_cycle();
    decode_info_t                exp_info;
    routine_e                    sel;
    logic [micro_addr_width-1:0] exp_addr;
    logic                        exp_end;
    logic                        exp_iflss;
    logic                        bnd;
    logic                        take_ext;
    logic                        take_trap;
    logic                        at_div;
    logic                        next_ext;
    @(negedge clk);
    exp_info = expect_info(opcode, modrm, rep, sop_l);
    sel = m_trap ? rt_trap :
          m_div ? rt_div_exc :
          m_ext ? (rep ? rt_ext_int_rep : rt_ext_int) : exp_info.routine;
    exp_addr = micro_addr_width'(routine_start(sel) + m_step);
    exp_end = (m_step == routine_length(sel) - 1);
    exp_iflss = !wr_ss && m_ss_ok;
    check_info(info, exp_info);
    check_addr("seq_addr", seq_addr, exp_addr);
    check_flag("end_seq", end_seq, exp_end);
    check_flag("iflss", iflss, exp_iflss);
    check_flag("tflm", tflm, events.tfl & m_tfl);
    check_flag("iflm", iflm, events.ifl & m_ifl);
    check_flag("ext_int", ext_int, m_ext);
    check_pulse("inta/nmia", {inta, nmia}, {m_inta, m_nmia});
    acks_seen |= {inta, nmia};
    // events only at an unstalled boundary outside the ss shadow
    bnd = exec_st && exp_end && !block;
    take_ext = bnd && exp_iflss && (events.nmir || (events.intr && events.ifl && m_ifl));
    take_trap = bnd && exp_iflss && events.tfl && m_tfl && !m_trap;
    at_div = (exp_addr == routine_start(rt_muldiv) + 1);
    blk_seen = block;
    // ack lands on the second edge after the external latch rises
    m_inta = (ack_wait == 1) && !events.nmir;
    m_nmia = (ack_wait == 1) && events.nmir;
    if (ack_wait == 1)
      ack_seen = 1'b1;
    if (ack_wait > 0)
      ack_wait--;
    row_done = 1'b0;
    if (!block)
    begin
      if (!exec_st)
      begin
        m_tfl = events.tfl;
        m_ifl = events.ifl;
        m_ss_ok = 1'b1;
      end
      else if (wr_ss)
        m_ss_ok = 1'b0;
      if (exec_st && at_div && m_hold < div_cycles + 1)
        m_hold++;
      else
      begin
        m_hold = 0;
        m_step = (!exec_st || exp_end) ? 0 : m_step + 1;
      end
      next_ext = take_ext ? 1'b1 : (exp_end ? 1'b0 : m_ext);
      if (next_ext && !m_ext)
        ack_wait = 2;
      m_ext = next_ext;
      m_trap = take_trap ? 1'b1 : (exp_end ? 1'b0 : m_trap);
      m_div = div_exc ? 1'b1 : (exp_end ? 1'b0 : m_div);
      row_done = bnd && !m_trap && !m_div && !m_ext;
    end
    @(posedge clk);
  endtask

  task automatic run_row(row_t r);
    event_req_t ev;
    opcode <= r.opcode;
    modrm <= random_bits(8);
    rep <= r.rep;
    sop_l <= r.sop_l;
    events <= r.ev;
    exec_st <= 1'b0;
    wr_ss <= 1'b0;
    div_exc <= 1'b0;
    // fetch until one edge gets through unstalled
    do
    begin
      block <= stall_bit(r.stall);
      run_cycle();
    end
    while (blk_seen);
    exec_st <= 1'b1;
    wr_ss <= r.ssw;
    ack_seen = 1'b0;
    acks_seen = 2'b00;
    row_done = 1'b0;
    while (!row_done)
    begin
      // request drops once acknowledged
      ev = r.ev;
      if (ack_seen)
      begin
        ev.intr = 1'b0;
        ev.nmir = 1'b0;
      end
      events <= ev;
      div_exc <= r.dexc && at_opcode_end();
      block <= stall_bit(r.stall);
      run_cycle();
    end
    check_pulse("acks per row", acks_seen, r.acks);
  endtask

  task automatic add_row(logic [7:0] op, logic rp, logic [2:0] so, logic [3:0] ev,
                         logic dx, logic sw, logic st, logic [1:0] ak);
    row_t r;
    r = {op, rp, so, ev, dx, sw, st, ak};
    rows.push_back(r);
  endtask

  initial
  begin
    int longest;
    int limit;
    longest = 0;
    wait (rows_ready);
    for (int i = 0; i < routine_count; i++)
    begin
      if (routine_length(routine_e'(i)) > longest)
        longest = routine_length(routine_e'(i));
    end
    limit = rows.size() * (longest + div_cycles + 10);
    repeat (limit) @(posedge clk);
    $display("timeout, the decode run did not finish within %0d cycles", limit);
    $display("Checks failed");
    $fatal(1, "watchdog expired");
  end

  initial
  begin
    rst = 1'b0;
    opcode = 8'h00;
    modrm = 8'h00;
    rep = 1'b0;
    sop_l = 3'b000;
    exec_st = 1'b0;
    block = 1'b0;
    div_exc = 1'b0;
    wr_ss = 1'b0;
    events = '0;
    lfsr = 32'hcfed;
    {m_step, m_hold, ack_wait} = '0;
    {m_trap, m_div, m_ext, m_tfl, m_ifl, m_ss_ok, m_inta, m_nmia} = '0;
    {row_done, ack_seen, blk_seen, acks_seen} = '0;
    rows_ready = 1'b0;
    // opcode, rep, sop_l, {intr nmir tfl ifl}, div_exc, wr_ss, stall, {inta nmia}
    add_row(8'h00, 0, 3'b000, 4'b0000, 0, 0, 0, 2'b00);
    add_row(8'h03, 0, 3'b101, 4'b0000, 0, 0, 1, 2'b00);
    add_row(8'h2b, 0, 3'b000, 4'b0000, 0, 0, 0, 2'b00);
    add_row(8'h04, 0, 3'b000, 4'b0000, 0, 0, 0, 2'b00);
    add_row(8'h3d, 0, 3'b110, 4'b0000, 0, 0, 0, 2'b00);
    add_row(8'h80, 0, 3'b000, 4'b0000, 0, 0, 0, 2'b00);
    add_row(8'h81, 0, 3'b101, 4'b0000, 0, 0, 1, 2'b00);
    add_row(8'h83, 0, 3'b000, 4'b0000, 0, 0, 0, 2'b00);
    add_row(8'h88, 0, 3'b000, 4'b0000, 0, 0, 0, 2'b00);
    add_row(8'h8b, 0, 3'b111, 4'b0000, 0, 0, 1, 2'b00);
    add_row(8'hb0, 0, 3'b000, 4'b0000, 0, 0, 0, 2'b00);
    add_row(8'hbb, 0, 3'b100, 4'b0000, 0, 0, 0, 2'b00);
    add_row(8'hc6, 0, 3'b000, 4'b0000, 0, 0, 0, 2'b00);
    add_row(8'hc7, 0, 3'b000, 4'b0000, 0, 0, 1, 2'b00);
    add_row(8'h50, 0, 3'b101, 4'b0000, 0, 0, 0, 2'b00);
    add_row(8'h5b, 0, 3'b000, 4'b0000, 0, 0, 0, 2'b00);
    add_row(8'h40, 0, 3'b000, 4'b0000, 0, 0, 0, 2'b00);
    add_row(8'h4f, 0, 3'b000, 4'b0000, 0, 0, 1, 2'b00);
    add_row(8'heb, 0, 3'b000, 4'b0000, 0, 0, 0, 2'b00);
    add_row(8'he8, 0, 3'b110, 4'b0000, 0, 0, 0, 2'b00);
    add_row(8'hf6, 1, 3'b000, 4'b0000, 0, 0, 0, 2'b00);
    add_row(8'hf7, 0, 3'b000, 4'b0000, 0, 0, 0, 2'b00);
    add_row(8'hf7, 0, 3'b000, 4'b0000, 1, 0, 0, 2'b00);
    add_row(8'hf7, 1, 3'b000, 4'b0000, 1, 0, 1, 2'b00);
    add_row(8'h0f, 0, 3'b000, 4'b0000, 0, 0, 0, 2'b00);
    add_row(8'hd8, 0, 3'b000, 4'b0000, 0, 0, 0, 2'b00);
    add_row(8'h01, 0, 3'b000, 4'b1001, 0, 0, 0, 2'b10);
    add_row(8'h01, 1, 3'b000, 4'b1001, 0, 0, 1, 2'b10);
    add_row(8'h89, 0, 3'b000, 4'b0100, 0, 0, 0, 2'b01);
    add_row(8'h29, 0, 3'b000, 4'b1000, 0, 0, 0, 2'b00);
    add_row(8'h31, 0, 3'b000, 4'b0010, 0, 0, 0, 2'b00);
    add_row(8'h31, 0, 3'b000, 4'b1011, 0, 1, 0, 2'b00);
    add_row(8'h05, 0, 3'b000, 4'b0101, 0, 0, 1, 2'b01);
    add_row(8'h33, 0, 3'b000, 4'b0010, 0, 0, 1, 2'b00);
    rows_ready = 1'b1;
    repeat (8) @(posedge clk);
    rst <= 1'b1;
    foreach (rows[i])
      run_row(rows[i]);
    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- decode_unit.f
hw/decode_pkg.sv
hw/opcode_lookup.sv
hw/micro_flags.sv
hw/event_control.sv
hw/micro_sequencer.sv
hw/decode_unit.sv
test/decode_unit_tb.sv

//--- Bender.yml
package:
  name: decode_unit

sources:
  - hw/decode_pkg.sv
  - hw/opcode_lookup.sv
  - hw/micro_flags.sv
  - hw/event_control.sv
  - hw/micro_sequencer.sv
  - hw/decode_unit.sv
  - target: test
    files:
      - test/decode_unit_tb.sv
